// ==== design/busPkg.sv ====
////////////////////
// Shared bus definitions
// Widths, AHB transfer and size encodings
// Controller states, core request encodings, RAM sizing
////////////////////

package busPkg;

  // Bus widths
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;

  // RAM sizing and timing
  localparam int ramWords      = 256;
  localparam int ramAddrBits   = $clog2(ramWords);
  localparam int ramWaitStates = 1;
  // Wide enough for a zero wait-state build too
  localparam int waitCntWidth  = $clog2(ramWaitStates + 2);

  typedef logic [addrWidth-1:0] addrT;
  typedef logic [dataWidth-1:0] dataT;

  // AHB transfer type
  typedef enum logic [1:0] {
    htransIdle = 2'b00, htransBusy = 2'b01, htransNonseq = 2'b10, htransSeq = 2'b11
  } htransT;

  // AHB transfer size
  typedef enum logic [2:0] {hsizeByte = 3'b000, hsizeHalf = 3'b001, hsizeWord = 3'b010} hsizeT;

  // Transfer controller states
  typedef enum logic [1:0] {adrPhase = 2'b00, dataPhase = 2'b01, holdPhase = 2'b10} busStateT;

  // Core side operation and access size
  typedef enum logic [1:0] {busNone = 2'b00, busWrite = 2'b01, busRead = 2'b10} busRwT;
  typedef enum logic [1:0] {accByte = 2'b00, accHalf = 2'b01, accWord = 2'b10} accSizeT;

endpackage

// ==== design/busFsm.sv ====
////////////////////
// AHB transfer-state controller
// Single NONSEQ transfers, stall/flush/commit toward the core
////////////////////

`timescale 1ns/1ns

module busFsm import busPkg::*; (
  input  logic     HCLK,
  input  logic     arstN,
  // Core side
  input  logic     Stall,
  input  logic     Flush,
  input  busRwT    BusRW,
  output logic     CaptureEn,
  output logic     BusStall,
  output logic     BusCommitted,
  // AHB side
  input  logic     HREADY,
  output htransT   HTRANS,
  output logic     HWRITE
);

  busStateT curState;
  busStateT nextState;
  logic     reqPending;
  logic     adrGo;

  // Core has a load or store waiting
  assign reqPending = (BusRW != busNone);

  // Address phase issued this cycle
  assign adrGo = (curState == adrPhase) & HREADY & reqPending & ~Flush;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      curState <= adrPhase;
    end else if (Flush) begin
      // Flush is a synchronous pipeline control
      curState <= adrPhase;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      adrPhase: begin
        if (adrGo) nextState = dataPhase;
      end
      dataPhase: begin
        // Slave back-pressure holds the data phase
        if (HREADY) nextState = holdPhase;
      end
      holdPhase: begin
        if (!Stall) nextState = adrPhase;
      end
      default: nextState = adrPhase;
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Busy while a request waits or data is in flight
  assign BusStall = ((curState == adrPhase) & reqPending) | (curState == dataPhase);

  // Past the address phase the access cannot be undone
  assign BusCommitted = (curState != adrPhase);

  assign HTRANS = adrGo ? htransNonseq : htransIdle;
  assign HWRITE = (BusRW == busWrite);

  // Load data sampled on the edge that ends the data phase
  assign CaptureEn = (curState == dataPhase) & HREADY;

endmodule

// ==== design/busMaster.sv ====
////////////////////
// Core request stage
// Size encoding, store lane replication
// Load lane select, extension and capture
////////////////////

`timescale 1ns/1ns

module busMaster import busPkg::*; (
  input  logic    HCLK,
  input  logic    arstN,
  // Core side
  input  busRwT   BusRW,
  input  addrT    Addr,
  input  accSizeT Size,
  input  logic    Unsigned,
  input  dataT    WriteData,
  input  logic    Stall,
  input  logic    Flush,
  output dataT    ReadData,
  output logic    BusStall,
  output logic    BusCommitted,
  // AHB side
  input  logic    HREADY,
  input  dataT    HRDATA,
  output addrT    HADDR,
  output hsizeT   HSIZE,
  output htransT  HTRANS,
  output logic    HWRITE,
  output dataT    HWDATA
);

  logic    captureEn;
  logic    adrDone;
  // Address-phase copies for the data phase
  logic [1:0] addrLoQ;
  accSizeT sizeQ;
  logic    unsignedQ;
  logic    writeQ;
  // Load path
  logic [7:0]  laneByte;
  logic [15:0] laneHalf;
  dataT        loadValue;

  busFsm busFsm_inst (
    .HCLK         (HCLK),
    .arstN        (arstN),
    .Stall        (Stall),
    .Flush        (Flush),
    .BusRW        (BusRW),
    .CaptureEn    (captureEn),
    .BusStall     (BusStall),
    .BusCommitted (BusCommitted),
    .HREADY       (HREADY),
    .HTRANS       (HTRANS),
    .HWRITE       (HWRITE)
  );

  // Address and size straight from the held request
  assign HADDR = Addr;
  always_comb begin
    case (Size)
      accByte: HSIZE = hsizeByte;
      accHalf: HSIZE = hsizeHalf;
      default: HSIZE = hsizeWord;
    endcase
  end

  assign adrDone = (HTRANS == htransNonseq);

  ////////////////////
  // Address-phase capture
  ////////////////////

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      writeQ <= 1'b0;
    end else if (adrDone) begin
      writeQ <= HWRITE;
    end
  end

  // Payload registers, no reset
  always_ff @(posedge HCLK) begin
    if (adrDone) begin
      addrLoQ   <= Addr[1:0];
      sizeQ     <= Size;
      unsignedQ <= Unsigned;
      // Store data replicated across all byte lanes
      case (Size)
        accByte: HWDATA <= {4{WriteData[7:0]}};
        accHalf: HWDATA <= {2{WriteData[15:0]}};
        default: HWDATA <= WriteData;
      endcase
    end
  end

  ////////////////////
  // Load extraction
  ////////////////////

  assign laneByte = HRDATA[{addrLoQ, 3'b000} +: 8];
  assign laneHalf = HRDATA[{addrLoQ[1], 4'b0000} +: 16];

  always_comb begin
    case (sizeQ)
      accByte: loadValue = {{(dataWidth-8){laneByte[7] & ~unsignedQ}}, laneByte};
      accHalf: loadValue = {{(dataWidth-16){laneHalf[15] & ~unsignedQ}}, laneHalf};
      default: loadValue = HRDATA;
    endcase
  end

  // Stores leave ReadData alone
  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      ReadData <= '0;
    end else if (captureEn & ~writeQ) begin
      ReadData <= loadValue;
    end
  end

endmodule

// ==== design/ahbRam.sv ====
////////////////////
// AHB-Lite slave RAM
// Byte-lane writes, fixed wait states per data phase
////////////////////

`timescale 1ns/1ns

module ahbRam import busPkg::*; (
  input  logic   HCLK,
  input  logic   arstN,
  input  addrT   HADDR,
  input  hsizeT  HSIZE,
  input  htransT HTRANS,
  input  logic   HWRITE,
  input  dataT   HWDATA,
  output dataT   HRDATA,
  output logic   HREADY
);

  dataT mem [ramWords];

  logic                    dataActive;
  logic [waitCntWidth-1:0] waitCnt;
  logic                    writeQ;
  logic [ramAddrBits+1:0]  addrQ;
  hsizeT                   sizeQ;
  logic                    adrAccept;
  logic                    lastCycle;
  logic [ramAddrBits-1:0]  wordIdx;
  logic [3:0]              byteEn;

  // Transfer accepted at the end of its address phase
  assign adrAccept = HREADY & (HTRANS == htransNonseq);

  assign wordIdx = addrQ[ramAddrBits+1:2];

  ////////////////////
  // Data phase control
  ////////////////////

  always_ff @(posedge HCLK or negedge arstN) begin
    if (!arstN) begin
      dataActive <= 1'b0;
      waitCnt    <= '0;
      writeQ     <= 1'b0;
    end else if (HREADY) begin
      dataActive <= adrAccept;
      waitCnt    <= '0;
      writeQ     <= HWRITE;
    end else begin
      // Wait state
      waitCnt <= waitCnt + 1'b1;
    end
  end

  // Address and size kept for the data phase
  always_ff @(posedge HCLK) begin
    if (adrAccept) begin
      addrQ <= HADDR[ramAddrBits+1:0];
      sizeQ <= HSIZE;
    end
  end

  // Ready when idle or once the wait states have run out
  assign HREADY = ~dataActive | (waitCnt == waitCntWidth'(ramWaitStates));
  assign lastCycle = dataActive & HREADY;

  ////////////////////
  // Memory array
  ////////////////////

  // Lanes picked by size and low address bits
  always_comb begin
    case (sizeQ)
      hsizeByte: byteEn = 4'b0001 << addrQ[1:0];
      hsizeHalf: byteEn = 4'b0011 << {addrQ[1], 1'b0};
      default:   byteEn = 4'b1111;
    endcase
  end

  always_ff @(posedge HCLK) begin
    if (lastCycle & writeQ) begin
      for (int i = 0; i < 4; i++) begin
        if (byteEn[i]) mem[wordIdx][8*i +: 8] <= HWDATA[8*i +: 8];
      end
    end
  end

  // Whole word on reads, master picks the lane
  assign HRDATA = (lastCycle & ~writeQ) ? mem[wordIdx] : '0;

endmodule

// ==== design/busTop.sv ====
////////////////////
// Bus interface top level
// Core request master plus wait-stated AHB RAM
////////////////////

`timescale 1ns/1ns

module busTop import busPkg::*; (
  input  logic    HCLK,
  input  logic    arstN,
  // Core request
  input  busRwT   BusRW,
  input  addrT    Addr,
  input  accSizeT Size,
  input  logic    Unsigned,
  input  dataT    WriteData,
  // Core pipeline control
  input  logic    Stall,
  input  logic    Flush,
  // Core response
  output dataT    ReadData,
  output logic    BusStall,
  output logic    BusCommitted
);

  ////////////////////
  // AHB-Lite wires
  ////////////////////

  addrT   haddr;
  hsizeT  hsize;
  htransT htrans;
  logic   hwrite;
  dataT   hwdata;
  dataT   hrdata;
  logic   hready;

  // Master side with the transfer controller inside
  busMaster busMaster_inst (
    .HCLK         (HCLK),
    .arstN        (arstN),
    .BusRW        (BusRW),
    .Addr         (Addr),
    .Size         (Size),
    .Unsigned     (Unsigned),
    .WriteData    (WriteData),
    .Stall        (Stall),
    .Flush        (Flush),
    .ReadData     (ReadData),
    .BusStall     (BusStall),
    .BusCommitted (BusCommitted),
    .HREADY       (hready),
    .HRDATA       (hrdata),
    .HADDR        (haddr),
    .HSIZE        (hsize),
    .HTRANS       (htrans),
    .HWRITE       (hwrite),
    .HWDATA       (hwdata)
  );

  // Slave memory
  ahbRam ahbRam_inst (
    .HCLK   (HCLK),
    .arstN  (arstN),
    .HADDR  (haddr),
    .HSIZE  (hsize),
    .HTRANS (htrans),
    .HWRITE (hwrite),
    .HWDATA (hwdata),
    .HRDATA (hrdata),
    .HREADY (hready)
  );

endmodule

// ==== sim/busTop_chk.sv ====
////////////////////
// AHB-Lite protocol assertions
// Bound into the bus top level
////////////////////

`timescale 1ns/1ns

module busTopChk import busPkg::*; (
  input logic   HCLK,
  input logic   arstN,
  input htransT htrans,
  input addrT   haddr,
  input hsizeT  hsize,
  input logic   hwrite,
  input logic   hready,
  input logic   BusStall,
  input logic   BusCommitted
);

  // Single transfers only, never BUSY or SEQ
  transKind: assert property (@(posedge HCLK) disable iff (!arstN)
    (htrans == htransIdle) || (htrans == htransNonseq))
    else $error("HTRANS carries a burst encoding");

  // Wait states must not disturb the address-phase controls
  dataHold: assert property (@(posedge HCLK) disable iff (!arstN)
    !hready |-> ($stable(haddr) && $stable(hsize) && $stable(hwrite)))
    else $error("HADDR, HSIZE or HWRITE changed during a wait state");

  // Commit only ever follows a stalled request that issued its address phase
  noEarlyCommit: assert property (@(posedge HCLK) disable iff (!arstN)
    $rose(BusCommitted) |-> $past(BusStall && (htrans == htransNonseq)))
    else $error("BusCommitted rose without a preceding address phase");

endmodule

bind busTop busTopChk busTopChk_inst (
  .HCLK         (HCLK),
  .arstN        (arstN),
  .htrans       (htrans),
  .haddr        (haddr),
  .hsize        (hsize),
  .hwrite       (hwrite),
  .hready       (hready),
  .BusStall     (BusStall),
  .BusCommitted (BusCommitted)
);

// ==== sim/busTb.sv ====
////////////////////
// Directed testbench for the bus interface
// Clock, reset, byte-array memory model, request tasks
// Directed and xorshift tests, watchdog, summary
////////////////////

`timescale 1ns/1ns

module busTb import busPkg::*; ();

  localparam int randomOps   = 200;
  localparam int stallCycles = 4;
  // Reset/word, fill, sub-word, flush, stall and random requests
  localparam int reqCount    = 2 + ramWords + 17 + 2 + 3 + randomOps;
  localparam int reqTimeout  = 20;

  logic    HCLK;
  logic    arstN;
  busRwT   BusRW;
  addrT    Addr;
  accSizeT Size;
  logic    Unsigned;
  dataT    WriteData;
  logic    Stall;
  logic    Flush;
  dataT    ReadData;
  logic    BusStall;
  logic    BusCommitted;

  // Byte-addressed reference copy of the RAM
  logic [7:0]  refMem [ramWords*4];
  logic [31:0] rngState = 32'heeba;
  int          mismatchCount = 0;
  int          otherErrors = 0;
  int          lastCycles;

  busTop busTop_inst (
    .HCLK         (HCLK),
    .arstN        (arstN),
    .BusRW        (BusRW),
    .Addr         (Addr),
    .Size         (Size),
    .Unsigned     (Unsigned),
    .WriteData    (WriteData),
    .Stall        (Stall),
    .Flush        (Flush),
    .ReadData     (ReadData),
    .BusStall     (BusStall),
    .BusCommitted (BusCommitted)
  );

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  // Watchdog, ten cycles per request
  initial begin
    #(reqCount * 10 * 20);
    $display("TIMEOUT: run did not finish within %0d cycles", reqCount * 10);
    $display("tests failed");
    $finish;
  end

  ////////////////////
  // Checks and model
  ////////////////////

  task automatic checkData(input string name, input dataT actual, input dataT expected);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, actual, expected);
    end
  endtask

  task automatic checkCycles(input string name, input int actual, input int expected);
    if (actual != expected) begin
      mismatchCount++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, name, actual, expected);
    end
  endtask

  // Xorshift32 step
  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  // Little-endian store, aligned down to the access size
  task automatic modelStore(input addrT a, input accSizeT s, input dataT d);
    int base;
    base = int'(a[ramAddrBits+1:0]);
    case (s)
      accByte: refMem[base] = d[7:0];
      accHalf: begin
        base = base & ~1;
        refMem[base]   = d[7:0];
        refMem[base+1] = d[15:8];
      end
      default: begin
        base = base & ~3;
        for (int i = 0; i < 4; i++) refMem[base+i] = d[8*i +: 8];
      end
    endcase
  endtask

  function automatic dataT modelLoad(input addrT a, input accSizeT s, input logic uns);
    int          base;
    logic [7:0]  b;
    logic [15:0] h;
    base = int'(a[ramAddrBits+1:0]);
    case (s)
      accByte: begin
        b = refMem[base];
        return uns ? {{(dataWidth-8){1'b0}}, b} : {{(dataWidth-8){b[7]}}, b};
      end
      accHalf: begin
        base = base & ~1;
        h = {refMem[base+1], refMem[base]};
        return uns ? {{(dataWidth-16){1'b0}}, h} : {{(dataWidth-16){h[15]}}, h};
      end
      default: begin
        base = base & ~3;
        return {refMem[base+3], refMem[base+2], refMem[base+1], refMem[base]};
      end
    endcase
  endfunction

  ////////////////////
  // Request tasks
  ////////////////////

  // Drive one request, count cycles until BusStall falls, then withdraw it
  task automatic issueRequest(input busRwT rw, input addrT a, input accSizeT s,
                              input logic uns, input dataT wd);
    logic released;
    @(negedge HCLK);
    BusRW      = rw;
    Addr       = a;
    Size       = s;
    Unsigned   = uns;
    WriteData  = wd;
    released   = 1'b0;
    lastCycles = 0;
    while (!released && lastCycles < reqTimeout) begin
      @(negedge HCLK);
      lastCycles++;
      released = !BusStall;
    end
    if (!released) begin
      otherErrors++;
      $display("ERROR at %0t ns: BusStall still high after %0d cycles", $time, reqTimeout);
    end
    // Withdrawn in the holdPhase cycle
    BusRW = busNone;
  endtask

  task automatic doWrite(input addrT a, input accSizeT s, input dataT d);
    issueRequest(busWrite, a, s, 1'b0, d);
    modelStore(a, s, d);
  endtask

  task automatic doRead(input addrT a, input accSizeT s, input logic uns);
    dataT expected;
    expected = modelLoad(a, s, uns);
    issueRequest(busRead, a, s, uns, '0);
    checkData("ReadData", ReadData, expected);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic resetAndWordTest();
    checkFlag("BusStall", BusStall, 1'b0);
    checkFlag("BusCommitted", BusCommitted, 1'b0);
    checkData("ReadData", ReadData, '0);
    doWrite(32'h0000_0040, accWord, 32'hcafe_1234);
    checkCycles("write latency", lastCycles, 3);
    doRead(32'h0000_0040, accWord, 1'b0);
    checkCycles("read latency", lastCycles, 3);
  endtask

  // Every word gets a value built from its whole index
  task automatic fillMemory();
    for (int i = 0; i < ramWords; i++) begin
      doWrite(addrT'(i * 4), accWord, {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'h3c});
    end
  endtask

  task automatic subWordTest();
    doWrite(32'h0000_0080, accWord, 32'h1122_3344);
    // Upper bits of WriteData are junk and must be ignored
    doWrite(32'h0000_0081, accByte, 32'hdead_00a5);
    doWrite(32'h0000_0082, accHalf, 32'hbeef_8001);
    doWrite(32'h0000_0080, accByte, 32'h0000_77c3);
    doRead(32'h0000_0080, accWord, 1'b0);
    checkData("merged word", ReadData, 32'h8001_a5c3);
    for (int lane = 0; lane < 4; lane++) begin
      doRead(addrT'(32'h80 + lane), accByte, 1'b1);
      doRead(addrT'(32'h80 + lane), accByte, 1'b0);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      doRead(addrT'(32'h80 + lane), accHalf, 1'b1);
      doRead(addrT'(32'h80 + lane), accHalf, 1'b0);
    end
  endtask

  task automatic flushTest();
    @(negedge HCLK);
    BusRW     = busWrite;
    Addr      = 32'h0000_00c0;
    Size      = accWord;
    WriteData = 32'h5555_aaaa;
    Flush     = 1'b1;
    @(negedge HCLK);
    checkFlag("BusCommitted", BusCommitted, 1'b0);
    BusRW = busNone;
    Flush = 1'b0;
    @(negedge HCLK);
    checkFlag("BusStall", BusStall, 1'b0);
    checkFlag("BusCommitted", BusCommitted, 1'b0);
    // Model untouched, so the old fill value is expected
    doRead(32'h0000_00c0, accWord, 1'b0);
  endtask

  task automatic stallHoldTest();
    dataT held;
    @(negedge HCLK);
    Stall = 1'b1;
    held = modelLoad(32'h0000_0084, accWord, 1'b0);
    doRead(32'h0000_0084, accWord, 1'b0);
    for (int k = 0; k < stallCycles; k++) begin
      @(negedge HCLK);
      checkFlag("BusCommitted", BusCommitted, 1'b1);
      checkFlag("BusStall", BusStall, 1'b0);
      checkData("ReadData", ReadData, held);
    end
    Stall = 1'b0;
    @(negedge HCLK);
    checkFlag("BusCommitted", BusCommitted, 1'b0);
    doWrite(32'h0000_0084, accHalf, 32'h0000_1357);
    doRead(32'h0000_0084, accWord, 1'b0);
    checkCycles("latency after stall", lastCycles, 3);
  endtask

  task automatic randomTrafficTest();
    logic [31:0] r;
    addrT        a;
    accSizeT     s;
    for (int n = 0; n < randomOps; n++) begin
      r = nextRand();
      a = nextRand();
      // Aligned accesses only
      case (r % 3)
        0: s = accByte;
        1: begin
          s = accHalf;
          a[0] = 1'b0;
        end
        default: begin
          s = accWord;
          a[1:0] = 2'b00;
        end
      endcase
      if (r[8]) doWrite(a, s, nextRand());
      else doRead(a, s, r[9]);
    end
  endtask

  initial begin
    arstN     = 1'b0;
    BusRW     = busNone;
    Addr      = '0;
    Size      = accWord;
    Unsigned  = 1'b0;
    WriteData = '0;
    Stall     = 1'b0;
    Flush     = 1'b0;
    repeat (3) @(negedge HCLK);
    arstN = 1'b1;
    resetAndWordTest();
    fillMemory();
    subWordTest();
    flushTest();
    stallHoldTest();
    randomTrafficTest();
    @(negedge HCLK);
    $display("Summary: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
    if (mismatchCount == 0 && otherErrors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/busPkg.sv
design/busFsm.sv
design/busMaster.sv
design/ahbRam.sv
design/busTop.sv
sim/busTop_chk.sv
sim/busTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module busTb -f list.f -o busTbSim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/busTbSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
